// File: cpu.f
source/cpu_pkg.sv
source/fetch_stage.sv
source/decode_stage.sv
source/execute_stage.sv
source/memory_stage.sv
source/cpu.sv
sim/clock_gen.sv
sim/tb_cpu.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the cpu testbench with Verilator.
# The exit status is non-zero when the build or the simulation fails.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module tb_cpu -f cpu.f -Mdir obj_dir -o sim_cpu
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit $status
fi

./obj_dir/sim_cpu
status=$?
if [ $status -ne 0 ]; then
	echo "simulation failed with status $status"
	exit $status
fi

exit 0

// File: sim/clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module clock_gen #(
	parameter int HALF_PERIOD = 20
) (
	output logic clock
);
	initial clock = 1'b0;

	always #(HALF_PERIOD) clock = ~clock;

endmodule

`default_nettype wire

// File: sim/tb_cpu.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cpu;
	import cpu_pkg::*;

	localparam logic [31:0] IO_BASE = 32'h8000_0000;
	localparam logic [31:0] IO_XOR = 32'h1357_9bdf;
	localparam int NUM_PROGS = 3;
	localparam int BODY_LEN = 150;
	localparam int PROG_LEN = BODY_LEN + 31;
	localparam int TIMEOUT_CYCLES = NUM_PROGS * PROG_LEN * 16;
	localparam int IMEM_WORDS = 256;
	localparam int DMEM_WORDS = 128;
	// kinds of data access in the expected stream
	localparam int K_DM_RD = 0;
	localparam int K_DM_WR = 1;
	localparam int K_IO_RD = 2;
	localparam int K_IO_WR = 3;

	logic clock;
	logic rst;
	logic do_system;
	logic IM_enable;
	logic [31:0] IM_address;
	logic [31:0] IM_out;
	logic IM_ready;
	logic DM_read;
	logic DM_write;
	logic [31:0] DM_address;
	logic [31:0] DM_in;
	logic [31:0] DM_out;
	logic DM_ready;
	logic IOM_read;
	logic IOM_write;
	logic [31:0] IOM_address;
	logic [31:0] IOM_in;
	logic [31:0] IOM_out;
	logic IOM_ready;
	logic alu_overflow;

	logic [31:0] imem [IMEM_WORDS];
	logic [31:0] dmem [DMEM_WORDS];
	logic [31:0] ref_mem [DMEM_WORDS];
	logic [31:0] model_regs [32];
	logic exp_ovf;
	int exp_kind [$];
	logic [31:0] exp_addr [$];
	logic [31:0] exp_data [$];
	int cycle_count = 0;

	clock_gen clock_gen0 (.clock(clock));

	cpu #(.RESET_PC(32'h0), .IO_BASE(IO_BASE)) dut0 (
		.clock(clock), .rst(rst), .do_system(do_system),
		.IM_enable(IM_enable), .IM_address(IM_address), .IM_out(IM_out), .IM_ready(IM_ready),
		.DM_read(DM_read), .DM_write(DM_write), .DM_address(DM_address), .DM_in(DM_in),
		.DM_out(DM_out), .DM_ready(DM_ready),
		.IOM_read(IOM_read), .IOM_write(IOM_write), .IOM_address(IOM_address),
		.IOM_in(IOM_in), .IOM_out(IOM_out), .IOM_ready(IOM_ready),
		.alu_overflow(alu_overflow)
	);

	// past the program every fetch sees a NOP
	assign IM_out = (IM_address < 32'd1024) ? imem[IM_address[9:2]] : 32'h0;
	assign DM_out = dmem[DM_address[8:2]];
	assign IOM_out = IOM_address ^ IO_XOR;

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("Something failed");
		$fatal(1);
	endtask

	task automatic check(input string what, input logic [31:0] got, input logic [31:0] expected);
		if (got !== expected)
			stop_run($sformatf("Error at %0t ns: %s is %h, expected %h", $time, what, got,
				expected));
	endtask

	function automatic logic coin();
		return ($urandom % 4) != 0;
	endfunction

	function automatic logic [31:0] fill_word(input int idx);
		return 32'(idx) * 32'h9e37_79b9 ^ 32'h2545_f491;
	endfunction

	function automatic logic [4:0] pick_reg();
		// mostly a few hot registers, so chains of dependent ops are common
		if ($urandom % 4 != 0)
			return 5'(1 + $urandom % 6);
		return 5'($urandom);
	endfunction

	function automatic logic [15:0] data_offset();
		// one access in four goes above IO_BASE
		if ($urandom % 4 == 0)
			return 16'h8000 | 16'(($urandom % 64) * 4);
		return 16'(($urandom % 64) * 4);
	endfunction

	function automatic logic [31:0] encode(input logic [5:0] op, input logic [4:0] rt,
		input logic [4:0] ra, input logic [15:0] low);
		return {op, rt, ra, low};
	endfunction

	task automatic tick(input logic rst_level);
		@(posedge clock);
		rst <= rst_level;
		do_system <= coin();
		IM_ready <= coin();
		DM_ready <= coin();
		IOM_ready <= coin();
	endtask

	task automatic build_program();
		int unsigned kind;
		int unsigned d;
		logic [4:0] rt;
		logic [4:0] ra;
		for (int i = 0; i < IMEM_WORDS; i++)
			imem[i] = 32'h0;
		// every register gets a known value first
		for (int k = 1; k < 32; k++)
			imem[k - 1] = encode(OP_MOVI, 5'(k), 5'd0, 16'($urandom));
		for (int i = 31; i < BODY_LEN; i++) begin
			kind = $urandom % 16;
			rt = pick_reg();
			ra = pick_reg();
			d = 1 + $urandom % 5;
			if (i + d > BODY_LEN)
				d = BODY_LEN - i;
			if (kind < 6)
				imem[i] = encode(6'(OP_ADD) + 6'(kind), rt, ra, {pick_reg(), 11'd0});
			else if (kind < 8)
				imem[i] = encode(OP_ADDI, rt, ra, 16'($urandom));
			else if (kind == 8)
				imem[i] = encode(OP_MOVI, rt, 5'd0, 16'($urandom));
			else if (kind < 13)
				imem[i] = encode(kind < 11 ? OP_LWI : OP_SWI, rt,
					($urandom % 2 == 0) ? 5'd0 : ra, data_offset());
			else if (kind == 13)
				imem[i] = encode(OP_BEQ, rt, ($urandom % 2 == 0) ? rt : ra, 16'(d));
			else if (kind == 14)
				imem[i] = encode(OP_BNE, rt, ($urandom % 2 == 0) ? rt : ra, 16'(d));
			else
				imem[i] = {OP_J, 26'(d)};
		end
		for (int k = 1; k < 32; k++)
			imem[BODY_LEN + k - 1] = encode(OP_SWI, 5'(k), 5'd0, 16'((63 + k) * 4));
	endtask

	task automatic expect_access(input int kind, input logic [31:0] addr,
		input logic [31:0] data);
		exp_kind.push_back(kind);
		exp_addr.push_back(addr);
		exp_data.push_back(data);
	endtask

	task automatic write_reg(input logic [4:0] rt, input logic [31:0] value);
		if (rt != 5'd0)
			model_regs[rt] = value;
	endtask

	// in-order execution of the whole program
	task automatic run_model();
		logic [31:0] pc;
		logic [31:0] next;
		logic [31:0] w;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] r;
		logic [31:0] sx;
		logic [4:0] rt;
		pc = 32'd0;
		exp_ovf = 1'b0;
		while (pc < PROG_LEN) begin
			w = imem[pc[7:0]];
			rt = w[25:21];
			a = model_regs[w[20:16]];
			b = model_regs[w[15:11]];
			sx = {{16{w[15]}}, w[15:0]};
			next = pc + 32'd1;
			case (w[31:26])
				OP_ADD, OP_ADDI: begin
					if (w[31:26] == OP_ADDI)
						b = sx;
					r = a + b;
					if (a[31] == b[31] && r[31] != a[31])
						exp_ovf = 1'b1;
					write_reg(rt, r);
				end
				OP_SUB: begin
					r = a - b;
					if (a[31] != b[31] && r[31] != a[31])
						exp_ovf = 1'b1;
					write_reg(rt, r);
				end
				OP_AND: write_reg(rt, a & b);
				OP_OR: write_reg(rt, a | b);
				OP_XOR: write_reg(rt, a ^ b);
				OP_SLT: write_reg(rt, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
				OP_MOVI: write_reg(rt, sx);
				OP_LWI: begin
					r = a + sx;
					if (r >= IO_BASE) begin
						expect_access(K_IO_RD, r, 32'h0);
						write_reg(rt, r ^ IO_XOR);
					end else begin
						expect_access(K_DM_RD, r, 32'h0);
						write_reg(rt, ref_mem[r[8:2]]);
					end
				end
				OP_SWI: begin
					r = a + sx;
					if (r >= IO_BASE) begin
						expect_access(K_IO_WR, r, model_regs[rt]);
					end else begin
						expect_access(K_DM_WR, r, model_regs[rt]);
						ref_mem[r[8:2]] = model_regs[rt];
					end
				end
				OP_BEQ: begin
					if (model_regs[rt] == a)
						next = pc + sx;
				end
				OP_BNE: begin
					if (model_regs[rt] != a)
						next = pc + sx;
				end
				OP_J: next = pc + {{6{w[25]}}, w[25:0]};
				default: ;
			endcase
			pc = next;
		end
	endtask

	task automatic note_access(input int kind, input logic [31:0] addr,
		input logic [31:0] data);
		if (exp_kind.size() == 0) begin
			stop_run($sformatf("unexpected access of kind %0d at address %h after the last one",
				kind, addr));
		end else begin
			check("access kind", kind, exp_kind.pop_front());
			check("access address", addr, exp_addr.pop_front());
			check("access data", data, exp_data.pop_front());
		end
	endtask

	task automatic run_program();
		tick(1'b1);
		build_program();
		run_model();
		repeat (7) tick(1'b1);
		@(negedge clock);
		check("alu_overflow after reset", 32'(alu_overflow), 32'd0);
		tick(1'b0);
		while (exp_kind.size() != 0)
			tick(1'b0);
		// let the NOP sled run a little to catch stray accesses
		repeat (8) tick(1'b0);
		@(negedge clock);
		check("alu_overflow at program end", 32'(alu_overflow), 32'(exp_ovf));
	endtask

	// every completed access is taken mid-cycle, where all levels are settled
	always @(negedge clock) begin
		if (!rst) begin
			check("IM_enable", 32'(IM_enable), 32'(do_system));
			if (DM_read && DM_ready)
				note_access(K_DM_RD, DM_address, 32'h0);
			if (DM_write && DM_ready) begin
				note_access(K_DM_WR, DM_address, DM_in);
				dmem[DM_address[8:2]] = DM_in;
			end
			if (IOM_read && IOM_ready)
				note_access(K_IO_RD, IOM_address, 32'h0);
			if (IOM_write && IOM_ready)
				note_access(K_IO_WR, IOM_address, IOM_in);
		end
	end

	always @(posedge clock) begin
		cycle_count = cycle_count + 1;
		if (cycle_count > TIMEOUT_CYCLES)
			stop_run("timeout: the programs did not finish within the cycle limit");
	end

	initial begin
		void'($urandom(32'h5287_7f28));
		rst = 1'b1;
		do_system = 1'b0;
		IM_ready = 1'b0;
		DM_ready = 1'b0;
		IOM_ready = 1'b0;
		for (int i = 0; i < DMEM_WORDS; i++) begin
			dmem[i] = fill_word(i);
			ref_mem[i] = fill_word(i);
		end
		for (int i = 0; i < 32; i++)
			model_regs[i] = 32'h0;
		for (int p = 0; p < NUM_PROGS; p++)
			run_program();
		$display("Everything OK");
		$finish;
	end

endmodule

`default_nettype wire

// File: source/cpu.sv
`timescale 1ns/1ps
`default_nettype none

module cpu #(
	parameter logic [cpu_pkg::XLEN-1:0] RESET_PC = '0,
	parameter logic [cpu_pkg::XLEN-1:0] IO_BASE = 32'h8000_0000
) (
	input  logic                     clock,
	input  logic                     rst,
	input  logic                     do_system,
	output logic                     IM_enable,
	output logic [cpu_pkg::XLEN-1:0] IM_address,
	input  logic [cpu_pkg::XLEN-1:0] IM_out,
	input  logic                     IM_ready,
	output logic                     DM_read,
	output logic                     DM_write,
	output logic [cpu_pkg::XLEN-1:0] DM_address,
	output logic [cpu_pkg::XLEN-1:0] DM_in,
	input  logic [cpu_pkg::XLEN-1:0] DM_out,
	input  logic                     DM_ready,
	output logic                     IOM_read,
	output logic                     IOM_write,
	output logic [cpu_pkg::XLEN-1:0] IOM_address,
	output logic [cpu_pkg::XLEN-1:0] IOM_in,
	input  logic [cpu_pkg::XLEN-1:0] IOM_out,
	input  logic                     IOM_ready,
	output logic                     alu_overflow
);
	import cpu_pkg::*;

	logic advance;
	logic mem_busy;
	logic [XLEN-1:0] if_instr;
	logic [XLEN-1:0] if_pc;
	logic if_valid;
	logic stall;
	logic redirect;
	logic [XLEN-1:0] redirect_pc;
	opcode_t id_op;
	logic [XLEN-1:0] id_src1;
	logic [XLEN-1:0] id_src2;
	logic [XLEN-1:0] id_store_data;
	logic [REG_ADDR_W-1:0] id_dest;
	logic id_reg_write;
	logic id_load;
	logic id_store;
	logic ex_write;
	logic [REG_ADDR_W-1:0] ex_addr;
	logic ex_is_load;
	logic [XLEN-1:0] ex_result;
	logic [XLEN-1:0] ex_store_data;
	logic ex_load;
	logic ex_store;
	logic mem_write;
	logic [REG_ADDR_W-1:0] mem_addr;
	logic [XLEN-1:0] mem_result;
	logic mem_is_load;
	logic wb_write;
	logic [REG_ADDR_W-1:0] wb_addr;
	logic [XLEN-1:0] wb_data;

	// whole pipeline moves together or not at all
	assign advance = do_system && IM_ready && !mem_busy;
	assign IM_enable = do_system;

	fetch_stage #(.RESET_PC(RESET_PC)) fetch0 (
		.clock(clock), .rst(rst), .advance(advance), .stall(stall),
		.redirect(redirect), .redirect_pc(redirect_pc), .IM_out(IM_out),
		.IM_address(IM_address), .if_instr(if_instr), .if_pc(if_pc), .if_valid(if_valid)
	);

	decode_stage decode0 (
		.clock(clock), .rst(rst), .advance(advance),
		.if_instr(if_instr), .if_pc(if_pc), .if_valid(if_valid),
		.mem_write(mem_write), .mem_addr(mem_addr), .mem_result(mem_result),
		.mem_is_load(mem_is_load),
		.ex_write(ex_write), .ex_addr(ex_addr), .ex_is_load(ex_is_load),
		.wb_write(wb_write), .wb_addr(wb_addr), .wb_data(wb_data),
		.stall(stall), .redirect(redirect), .redirect_pc(redirect_pc),
		.id_op(id_op), .id_src1(id_src1), .id_src2(id_src2), .id_store_data(id_store_data),
		.id_dest(id_dest), .id_reg_write(id_reg_write), .id_load(id_load), .id_store(id_store)
	);

	execute_stage execute0 (
		.clock(clock), .rst(rst), .advance(advance),
		.id_op(id_op), .id_src1(id_src1), .id_src2(id_src2), .id_store_data(id_store_data),
		.id_dest(id_dest), .id_reg_write(id_reg_write), .id_load(id_load), .id_store(id_store),
		.ex_write(ex_write), .ex_addr(ex_addr), .ex_is_load(ex_is_load),
		.ex_result(ex_result), .ex_store_data(ex_store_data),
		.ex_load(ex_load), .ex_store(ex_store), .alu_overflow(alu_overflow)
	);

	memory_stage #(.IO_BASE(IO_BASE)) memory0 (
		.clock(clock), .rst(rst), .advance(advance),
		.ex_write(ex_write), .ex_addr(ex_addr), .ex_is_load(ex_is_load),
		.ex_result(ex_result), .ex_store_data(ex_store_data),
		.ex_load(ex_load), .ex_store(ex_store),
		.mem_write(mem_write), .mem_addr(mem_addr), .mem_result(mem_result),
		.mem_is_load(mem_is_load), .mem_busy(mem_busy),
		.wb_write(wb_write), .wb_addr(wb_addr), .wb_data(wb_data),
		.DM_read(DM_read), .DM_write(DM_write), .DM_address(DM_address), .DM_in(DM_in),
		.DM_out(DM_out), .DM_ready(DM_ready),
		.IOM_read(IOM_read), .IOM_write(IOM_write), .IOM_address(IOM_address),
		.IOM_in(IOM_in), .IOM_out(IOM_out), .IOM_ready(IOM_ready)
	);

endmodule

`default_nettype wire

// File: source/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

	localparam int XLEN = 32;
	localparam int REG_ADDR_W = 5;
	localparam int IMM_W = 16;
	localparam int JIMM_W = 26;
	localparam int OPC_W = 6;

	// low bit of each instruction field
	localparam int OPC_LSB = 26;
	localparam int RT_LSB = 21;
	localparam int RA_LSB = 16;
	localparam int RB_LSB = 11;
	localparam int IMM_LSB = 0;
	localparam int JIMM_LSB = 0;

	typedef enum logic [OPC_W-1:0] {
		OP_NOP  = 6'd0,
		OP_ADD  = 6'd1,
		OP_SUB  = 6'd2,
		OP_AND  = 6'd3,
		OP_OR   = 6'd4,
		OP_XOR  = 6'd5,
		OP_SLT  = 6'd6,
		OP_ADDI = 6'd7,
		OP_MOVI = 6'd8,
		OP_LWI  = 6'd9,
		OP_SWI  = 6'd10,
		OP_BEQ  = 6'd11,
		OP_BNE  = 6'd12,
		OP_J    = 6'd13
	} opcode_t;

	function automatic logic [OPC_W-1:0] get_opcode(input logic [XLEN-1:0] instr);
		return instr[OPC_LSB +: OPC_W];
	endfunction

	function automatic logic [REG_ADDR_W-1:0] get_rt(input logic [XLEN-1:0] instr);
		return instr[RT_LSB +: REG_ADDR_W];
	endfunction

	function automatic logic [REG_ADDR_W-1:0] get_ra(input logic [XLEN-1:0] instr);
		return instr[RA_LSB +: REG_ADDR_W];
	endfunction

	function automatic logic [REG_ADDR_W-1:0] get_rb(input logic [XLEN-1:0] instr);
		return instr[RB_LSB +: REG_ADDR_W];
	endfunction

	function automatic logic [IMM_W-1:0] get_imm(input logic [XLEN-1:0] instr);
		return instr[IMM_LSB +: IMM_W];
	endfunction

	function automatic logic [JIMM_W-1:0] get_jimm(input logic [XLEN-1:0] instr);
		return instr[JIMM_LSB +: JIMM_W];
	endfunction

endpackage

`default_nettype wire

// File: source/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
	input  logic                           clock,
	input  logic                           rst,
	input  logic                           advance,
	input  logic [cpu_pkg::XLEN-1:0]       if_instr,
	input  logic [cpu_pkg::XLEN-1:0]       if_pc,
	input  logic                           if_valid,
	input  logic                           mem_write,
	input  logic [cpu_pkg::REG_ADDR_W-1:0] mem_addr,
	input  logic [cpu_pkg::XLEN-1:0]       mem_result,
	input  logic                           mem_is_load,
	input  logic                           ex_write,
	input  logic [cpu_pkg::REG_ADDR_W-1:0] ex_addr,
	input  logic                           ex_is_load,
	input  logic                           wb_write,
	input  logic [cpu_pkg::REG_ADDR_W-1:0] wb_addr,
	input  logic [cpu_pkg::XLEN-1:0]       wb_data,
	output logic                           stall,
	output logic                           redirect,
	output logic [cpu_pkg::XLEN-1:0]       redirect_pc,
	output cpu_pkg::opcode_t               id_op,
	output logic [cpu_pkg::XLEN-1:0]       id_src1,
	output logic [cpu_pkg::XLEN-1:0]       id_src2,
	output logic [cpu_pkg::XLEN-1:0]       id_store_data,
	output logic [cpu_pkg::REG_ADDR_W-1:0] id_dest,
	output logic                           id_reg_write,
	output logic                           id_load,
	output logic                           id_store
);
	import cpu_pkg::*;

	logic [XLEN-1:0] regs [2**REG_ADDR_W];
	opcode_t op;
	logic [REG_ADDR_W-1:0] rt;
	logic [REG_ADDR_W-1:0] ra;
	logic [REG_ADDR_W-1:0] rb;
	logic [IMM_W-1:0] imm;
	logic [JIMM_W-1:0] jimm;
	logic use_ra;
	logic use_rb;
	logic use_rt;
	logic use_imm;
	logic writes;
	logic is_load;
	logic is_store;
	logic is_beq;
	logic is_bne;
	logic is_jump;
	logic [XLEN-1:0] ra_val;
	logic [XLEN-1:0] rb_val;
	logic [XLEN-1:0] rt_val;
	logic [XLEN-1:0] imm_ext;
	logic [XLEN-1:0] br_target;
	logic [XLEN-1:0] j_target;
	logic ex_hit;
	logic mem_hit;
	logic load_hit;
	logic issue;

	// memory stage result first, then writeback, then the array
	function automatic logic [XLEN-1:0] operand(input logic [REG_ADDR_W-1:0] a);
		if (a == '0)
			return '0;
		else if (mem_write && !mem_is_load && mem_addr == a)
			return mem_result;
		else if (wb_write && wb_addr == a)
			return wb_data;
		else
			return regs[a];
	endfunction

	function automatic logic reads(input logic [REG_ADDR_W-1:0] a);
		return (use_ra && ra == a) || (use_rb && rb == a) || (use_rt && rt == a);
	endfunction

	assign op = opcode_t'(get_opcode(if_instr));
	assign rt = get_rt(if_instr);
	assign ra = get_ra(if_instr);
	assign rb = get_rb(if_instr);
	assign imm = get_imm(if_instr);
	assign jimm = get_jimm(if_instr);

	always_comb begin
		use_ra = 1'b0;
		use_rb = 1'b0;
		use_rt = 1'b0;
		use_imm = 1'b0;
		writes = 1'b0;
		is_load = 1'b0;
		is_store = 1'b0;
		is_beq = 1'b0;
		is_bne = 1'b0;
		is_jump = 1'b0;
		case (op)
			OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLT: begin
				use_ra = 1'b1;
				use_rb = 1'b1;
				writes = 1'b1;
			end
			OP_ADDI: begin
				use_ra = 1'b1;
				use_imm = 1'b1;
				writes = 1'b1;
			end
			OP_MOVI: begin
				use_imm = 1'b1;
				writes = 1'b1;
			end
			OP_LWI: begin
				use_ra = 1'b1;
				use_imm = 1'b1;
				writes = 1'b1;
				is_load = 1'b1;
			end
			OP_SWI: begin
				use_ra = 1'b1;
				use_rt = 1'b1;
				use_imm = 1'b1;
				is_store = 1'b1;
			end
			OP_BEQ, OP_BNE: begin
				use_ra = 1'b1;
				use_rt = 1'b1;
				is_beq = (op == OP_BEQ);
				is_bne = (op == OP_BNE);
			end
			OP_J: is_jump = 1'b1;
			default: ;
		endcase
	end

	always_comb begin
		ra_val = operand(ra);
		rb_val = operand(rb);
		rt_val = operand(rt);
		ex_hit = reads(ex_addr);
		mem_hit = reads(mem_addr);
	end

	// alu results in flight are not visible here yet, loads one stage longer
	assign load_hit = (ex_is_load && ex_hit) || (mem_is_load && mem_hit);
	assign stall = if_valid && ((ex_write && ex_hit) || load_hit);
	assign issue = if_valid && !stall;

	assign imm_ext = {{(XLEN-IMM_W){imm[IMM_W-1]}}, imm};
	assign br_target = if_pc + {imm_ext[XLEN-3:0], 2'b00};
	assign j_target = if_pc + {{(XLEN-JIMM_W-2){jimm[JIMM_W-1]}}, jimm, 2'b00};
	assign redirect = issue && (is_jump || (is_beq && rt_val == ra_val) ||
		(is_bne && rt_val != ra_val));
	assign redirect_pc = is_jump ? j_target : br_target;

	always_ff @(posedge clock) begin
		if (advance && wb_write)
			regs[wb_addr] <= wb_data;
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			id_op <= OP_NOP;
			id_reg_write <= 1'b0;
			id_load <= 1'b0;
			id_store <= 1'b0;
		end else if (advance) begin
			id_op <= issue ? op : OP_NOP;
			id_reg_write <= issue && writes && rt != '0;
			id_load <= issue && is_load;
			id_store <= issue && is_store;
		end
	end

	always_ff @(posedge clock) begin
		if (advance) begin
			id_src1 <= ra_val;
			id_src2 <= use_imm ? imm_ext : rb_val;
			id_store_data <= rt_val;
			id_dest <= rt;
		end
	end

	r0_never_written: assert property (@(posedge clock) disable iff (rst)
		(advance && wb_write) |-> wb_addr != '0);

endmodule

`default_nettype wire

// File: source/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
	input  logic                           clock,
	input  logic                           rst,
	input  logic                           advance,
	input  cpu_pkg::opcode_t               id_op,
	input  logic [cpu_pkg::XLEN-1:0]       id_src1,
	input  logic [cpu_pkg::XLEN-1:0]       id_src2,
	input  logic [cpu_pkg::XLEN-1:0]       id_store_data,
	input  logic [cpu_pkg::REG_ADDR_W-1:0] id_dest,
	input  logic                           id_reg_write,
	input  logic                           id_load,
	input  logic                           id_store,
	output logic                           ex_write,
	output logic [cpu_pkg::REG_ADDR_W-1:0] ex_addr,
	output logic                           ex_is_load,
	output logic [cpu_pkg::XLEN-1:0]       ex_result,
	output logic [cpu_pkg::XLEN-1:0]       ex_store_data,
	output logic                           ex_load,
	output logic                           ex_store,
	output logic                           alu_overflow
);
	import cpu_pkg::*;

	logic [XLEN-1:0] alu_result;
	logic overflow;

	always_comb begin
		alu_result = '0;
		overflow = 1'b0;
		case (id_op)
			OP_ADD, OP_ADDI, OP_LWI, OP_SWI: begin
				alu_result = id_src1 + id_src2;
				// address adds never flag
				overflow = (id_op != OP_LWI) && (id_op != OP_SWI) &&
					(id_src1[XLEN-1] == id_src2[XLEN-1]) &&
					(alu_result[XLEN-1] != id_src1[XLEN-1]);
			end
			OP_SUB: begin
				alu_result = id_src1 - id_src2;
				overflow = (id_src1[XLEN-1] != id_src2[XLEN-1]) &&
					(alu_result[XLEN-1] != id_src1[XLEN-1]);
			end
			OP_AND: alu_result = id_src1 & id_src2;
			OP_OR: alu_result = id_src1 | id_src2;
			OP_XOR: alu_result = id_src1 ^ id_src2;
			OP_SLT: alu_result = {{(XLEN-1){1'b0}}, $signed(id_src1) < $signed(id_src2)};
			OP_MOVI: alu_result = id_src2;
			default: ;
		endcase
	end

	// destination of the instruction now in the alu
	assign ex_write = id_reg_write;
	assign ex_addr = id_dest;
	assign ex_is_load = id_load && id_reg_write;

	always_ff @(posedge clock) begin
		if (rst) begin
			ex_load <= 1'b0;
			ex_store <= 1'b0;
			alu_overflow <= 1'b0;
		end else if (advance) begin
			ex_load <= id_load;
			ex_store <= id_store;
			if (overflow)
				alu_overflow <= 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (advance) begin
			ex_result <= alu_result;
			ex_store_data <= id_store_data;
		end
	end

endmodule

`default_nettype wire

// File: source/fetch_stage.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_stage #(
	parameter logic [cpu_pkg::XLEN-1:0] RESET_PC = '0
) (
	input  logic                     clock,
	input  logic                     rst,
	input  logic                     advance,
	input  logic                     stall,
	input  logic                     redirect,
	input  logic [cpu_pkg::XLEN-1:0] redirect_pc,
	input  logic [cpu_pkg::XLEN-1:0] IM_out,
	output logic [cpu_pkg::XLEN-1:0] IM_address,
	output logic [cpu_pkg::XLEN-1:0] if_instr,
	output logic [cpu_pkg::XLEN-1:0] if_pc,
	output logic                     if_valid
);
	import cpu_pkg::*;

	logic [XLEN-1:0] pc;

	assign IM_address = pc;

	always_ff @(posedge clock) begin
		if (rst) begin
			pc <= RESET_PC;
			if_valid <= 1'b0;
		end else if (advance) begin
			if (redirect) begin
				// word fetched this cycle is on the wrong path
				pc <= redirect_pc;
				if_valid <= 1'b0;
			end else if (!stall) begin
				pc <= pc + 32'd4;
				if_valid <= 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (advance && !redirect && !stall) begin
			if_instr <= IM_out;
			if_pc <= pc;
		end
	end

endmodule

`default_nettype wire

// File: source/memory_stage.sv
`timescale 1ns/1ps
`default_nettype none

module memory_stage #(
	parameter logic [cpu_pkg::XLEN-1:0] IO_BASE = 32'h8000_0000
) (
	input  logic                           clock,
	input  logic                           rst,
	input  logic                           advance,
	input  logic                           ex_write,
	input  logic [cpu_pkg::REG_ADDR_W-1:0] ex_addr,
	input  logic                           ex_is_load,
	input  logic [cpu_pkg::XLEN-1:0]       ex_result,
	input  logic [cpu_pkg::XLEN-1:0]       ex_store_data,
	input  logic                           ex_load,
	input  logic                           ex_store,
	output logic                           mem_write,
	output logic [cpu_pkg::REG_ADDR_W-1:0] mem_addr,
	output logic [cpu_pkg::XLEN-1:0]       mem_result,
	output logic                           mem_is_load,
	output logic                           mem_busy,
	output logic                           wb_write,
	output logic [cpu_pkg::REG_ADDR_W-1:0] wb_addr,
	output logic [cpu_pkg::XLEN-1:0]       wb_data,
	output logic                           DM_read,
	output logic                           DM_write,
	output logic [cpu_pkg::XLEN-1:0]       DM_address,
	output logic [cpu_pkg::XLEN-1:0]       DM_in,
	input  logic [cpu_pkg::XLEN-1:0]       DM_out,
	input  logic                           DM_ready,
	output logic                           IOM_read,
	output logic                           IOM_write,
	output logic [cpu_pkg::XLEN-1:0]       IOM_address,
	output logic [cpu_pkg::XLEN-1:0]       IOM_in,
	input  logic [cpu_pkg::XLEN-1:0]       IOM_out,
	input  logic                           IOM_ready
);
	import cpu_pkg::*;

	logic is_io;
	logic rd_req;
	logic wr_req;
	logic ready;
	logic complete;
	logic done;
	logic [XLEN-1:0] port_data;
	logic [XLEN-1:0] ld_data;
	logic [XLEN-1:0] load_value;

	assign is_io = ex_result >= IO_BASE;
	assign rd_req = ex_load && !done;
	assign wr_req = ex_store && !done;
	assign ready = is_io ? IOM_ready : DM_ready;
	assign complete = (rd_req || wr_req) && ready;
	assign mem_busy = (rd_req || wr_req) && !ready;

	assign DM_read = rd_req && !is_io;
	assign DM_write = wr_req && !is_io;
	assign DM_address = ex_result;
	assign DM_in = ex_store_data;
	assign IOM_read = rd_req && is_io;
	assign IOM_write = wr_req && is_io;
	assign IOM_address = ex_result;
	assign IOM_in = ex_store_data;

	assign port_data = is_io ? IOM_out : DM_out;
	assign load_value = done ? ld_data : port_data;
	assign mem_result = ex_result;

	// strobe drops once served, until the next instruction arrives
	always_ff @(posedge clock) begin
		if (rst || advance)
			done <= 1'b0;
		else if (complete)
			done <= 1'b1;
	end

	always_ff @(posedge clock) begin
		if (complete && ex_load)
			ld_data <= port_data;
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			mem_write <= 1'b0;
			mem_is_load <= 1'b0;
			wb_write <= 1'b0;
		end else if (advance) begin
			mem_write <= ex_write;
			mem_is_load <= ex_is_load;
			wb_write <= mem_write;
		end
	end

	always_ff @(posedge clock) begin
		if (advance) begin
			mem_addr <= ex_addr;
			wb_addr <= mem_addr;
			wb_data <= mem_is_load ? load_value : ex_result;
		end
	end

	read_write_exclusive: assert property (@(posedge clock) disable iff (rst)
		!((DM_read || IOM_read) && (DM_write || IOM_write)));

	// a pending access must hold the whole pipeline
	access_not_skipped: assert property (@(posedge clock) disable iff (rst)
		mem_busy |-> !advance);

endmodule

`default_nettype wire
